// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // ########################################
    // widths
    // ########################################
    localparam int xlen       = 32;
    localparam int hart_num   = 2;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]              word_t;
    typedef logic [$clog2(hart_num)-1:0]  hart_t;
    typedef logic [reg_addr_w-1:0]        reg_addr_t;

    // ########################################
    // encodings
    // ########################################
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011
    } opcode_e;

    // pass_b forwards operand b unchanged, which is how lui writes its immediate.
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        logic      use_imm;
        logic      wb_en;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      br_ne;
    } uop_t;

    // each hart starts in its own code region.
    localparam word_t hart_reset_pc [hart_num] = '{32'h0000_0000, 32'h0000_0400};

endpackage

// ==== hw/mem_access_if.sv ====
`timescale 1ns/1ps

interface mem_access_if;

    logic          fetch_req;
    rv_pkg::word_t fetch_addr;
    rv_pkg::word_t inst;
    logic          inst_valid;

    logic          data_req;
    logic          data_we;
    rv_pkg::word_t data_addr;
    rv_pkg::word_t data_wdata;
    rv_pkg::word_t load_data;
    logic          mem_stall;

    modport pipe (
        output fetch_req, fetch_addr, data_req, data_we, data_addr, data_wdata,
        input  inst, inst_valid, load_data, mem_stall
    );

    modport port (
        input  fetch_req, fetch_addr, data_req, data_we, data_addr, data_wdata,
        output inst, inst_valid, load_data, mem_stall
    );

endinterface

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  rv_pkg::word_t inst,
    output rv_pkg::uop_t  uop
);
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // alt picks sub over add and sra over srl.
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        uop     = '0;
        uop.rs1 = inst[19:15];
        uop.rs2 = inst[24:20];
        uop.rd  = inst[11:7];
        case (rv_pkg::opcode_e'(inst[6:0]))
            rv_pkg::opc_op: begin
                uop.valid  = (funct7 == 7'b0) ||
                             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                uop.alu_op = alu_sel(funct3, inst[30]);
                uop.wb_en  = 1'b1;
            end
            rv_pkg::opc_op_imm: begin
                // only the shift forms constrain funct7.
                uop.valid   = (funct3 != 3'b001 && funct3 != 3'b101) || (funct7 == 7'b0) ||
                              (funct3 == 3'b101 && funct7 == 7'b0100000);
                uop.alu_op  = alu_sel(funct3, funct3 == 3'b101 && inst[30]);
                uop.use_imm = 1'b1;
                uop.imm     = imm_i;
                uop.wb_en   = 1'b1;
            end
            rv_pkg::opc_lui: begin
                uop.valid   = 1'b1;
                uop.alu_op  = rv_pkg::alu_pass_b;
                uop.use_imm = 1'b1;
                uop.imm     = {inst[31:12], 12'b0};
                uop.wb_en   = 1'b1;
            end
            rv_pkg::opc_load: begin
                uop.valid   = (funct3 == 3'b010);
                uop.use_imm = 1'b1;
                uop.imm     = imm_i;
                uop.wb_en   = 1'b1;
                uop.is_load = 1'b1;
            end
            rv_pkg::opc_store: begin
                uop.valid    = (funct3 == 3'b010);
                uop.use_imm  = 1'b1;
                uop.imm      = imm_s;
                uop.is_store = 1'b1;
            end
            rv_pkg::opc_branch: begin
                uop.valid     = (funct3[2:1] == 2'b00);
                uop.imm       = imm_b;
                uop.is_branch = 1'b1;
                uop.br_ne     = funct3[0];
            end
            default: begin
                uop.valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  rv_pkg::uop_t      uop,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::word_t     rs1_val,
    input  rv_pkg::word_t     rs2_val,
    input  logic              exmem_valid,
    input  rv_pkg::reg_addr_t exmem_rd,
    input  rv_pkg::word_t     exmem_data,
    input  logic              exwb_valid,
    input  rv_pkg::reg_addr_t exwb_rd,
    input  rv_pkg::word_t     exwb_data,
    output rv_pkg::word_t     result,
    output rv_pkg::word_t     store_data,
    output logic              br_taken,
    output rv_pkg::word_t     br_target
);
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t rs2_fwd;

    // the younger producer in the memory stage wins; x0 keeps its register value.
    function automatic rv_pkg::word_t fwd_sel(input rv_pkg::reg_addr_t rs,
                                              input rv_pkg::word_t rf_val);
        if (rs == '0) begin
            return rf_val;
        end
        if (exmem_valid && exmem_rd == rs) begin
            return exmem_data;
        end
        if (exwb_valid && exwb_rd == rs) begin
            return exwb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a    = fwd_sel(uop.rs1, rs1_val);
        rs2_fwd = fwd_sel(uop.rs2, rs2_val);
        op_b    = uop.use_imm ? uop.imm : rs2_fwd;
        case (uop.alu_op)
            rv_pkg::alu_sub:    result = op_a - op_b;
            rv_pkg::alu_and:    result = op_a & op_b;
            rv_pkg::alu_or:     result = op_a | op_b;
            rv_pkg::alu_xor:    result = op_a ^ op_b;
            rv_pkg::alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   result = {31'b0, op_a < op_b};
            rv_pkg::alu_sll:    result = op_a << op_b[4:0];
            rv_pkg::alu_srl:    result = op_a >> op_b[4:0];
            rv_pkg::alu_sra:    result = $signed(op_a) >>> op_b[4:0];
            rv_pkg::alu_pass_b: result = op_b;
            default:            result = op_a + op_b;
        endcase
    end

    assign store_data = rs2_fwd;
    assign br_taken   = uop.valid && uop.is_branch && ((op_a == rs2_fwd) != uop.br_ne);
    assign br_target  = pc + uop.imm;

endmodule

// ==== hw/regfile_bank.sv ====
`timescale 1ns/1ps

module regfile_bank (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::hart_t     r_hart,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  logic              w_en,
    input  rv_pkg::hart_t     w_hart,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata
);
    rv_pkg::word_t regs [rv_pkg::hart_num][2**rv_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int h = 0; h < rv_pkg::hart_num; h++) begin
                for (int r = 0; r < 2**rv_pkg::reg_addr_w; r++) begin
                    regs[h][r] <= '0;
                end
            end
        end else if (w_en && waddr != '0) begin
            regs[w_hart][waddr] <= wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle.
    assign rdata1 = (w_en && w_hart == r_hart && waddr == raddr1 && raddr1 != '0) ?
                    wdata : regs[r_hart][raddr1];
    assign rdata2 = (w_en && w_hart == r_hart && waddr == raddr2 && raddr2 != '0) ?
                    wdata : regs[r_hart][raddr2];

endmodule

// ==== hw/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
    mem_access_if.port    mem,
    output logic          mem_req,
    output logic          mem_we,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    input  rv_pkg::word_t mem_rdata,
    input  logic          mem_ready
);
    // ########################################
    // bus side
    // ########################################
    assign mem_req   = mem.data_req || mem.fetch_req;
    assign mem_we    = mem.data_req && mem.data_we;
    assign mem_addr  = mem.data_req ? mem.data_addr : mem.fetch_addr;
    assign mem_wdata = mem_we ? mem.data_wdata : '0;

    // ########################################
    // pipeline side
    // ########################################
    // rdata is valid in the ready cycle, so both returns are plain taps.
    assign mem.inst       = mem_rdata;
    assign mem.inst_valid = mem.fetch_req && !mem.data_req && mem_ready;
    assign mem.load_data  = mem_rdata;

    // a fetch without ready just gives up its turn; only data accesses stall.
    assign mem.mem_stall  = mem.data_req && !mem_ready;

endmodule

// ==== hw/hart_pipe.sv ====
`timescale 1ns/1ps

module hart_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::uop_t      dec_uop,
    input  rv_pkg::word_t     ex_result,
    input  rv_pkg::word_t     ex_store_data,
    input  logic              br_taken,
    input  rv_pkg::word_t     br_target,
    input  rv_pkg::word_t     rf_rdata1,
    input  rv_pkg::word_t     rf_rdata2,
    mem_access_if.pipe        mem,
    output rv_pkg::hart_t     cur_hart,
    output rv_pkg::word_t     ifid_inst,
    output rv_pkg::word_t     ifid_pc,
    output rv_pkg::uop_t      idex_uop,
    output rv_pkg::word_t     idex_pc,
    output rv_pkg::word_t     idex_rs1_val,
    output rv_pkg::word_t     idex_rs2_val,
    output logic              exmem_fwd_valid,
    output rv_pkg::reg_addr_t exmem_fwd_rd,
    output rv_pkg::word_t     exmem_fwd,
    output logic              exwb_fwd_valid,
    output rv_pkg::reg_addr_t exwb_fwd_rd,
    output rv_pkg::word_t     exwb_fwd,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_waddr,
    output rv_pkg::word_t     rf_wdata
);
    logic              run_q;
    logic              adv;
    rv_pkg::word_t     pc_q         [rv_pkg::hart_num];
    logic              ifid_valid   [rv_pkg::hart_num];
    rv_pkg::word_t     ifid_inst_q  [rv_pkg::hart_num];
    rv_pkg::word_t     ifid_pc_q    [rv_pkg::hart_num];
    logic              idex_valid   [rv_pkg::hart_num];
    rv_pkg::uop_t      idex_uop_q   [rv_pkg::hart_num];
    rv_pkg::word_t     idex_pc_q    [rv_pkg::hart_num];
    rv_pkg::word_t     idex_rs1_q   [rv_pkg::hart_num];
    rv_pkg::word_t     idex_rs2_q   [rv_pkg::hart_num];
    logic              exmem_wb     [rv_pkg::hart_num];
    logic              exmem_ld     [rv_pkg::hart_num];
    logic              exmem_st     [rv_pkg::hart_num];
    rv_pkg::reg_addr_t exmem_rd     [rv_pkg::hart_num];
    rv_pkg::word_t     exmem_result [rv_pkg::hart_num];
    rv_pkg::word_t     exmem_sdata  [rv_pkg::hart_num];
    logic              exwb_valid   [rv_pkg::hart_num];
    rv_pkg::reg_addr_t exwb_rd      [rv_pkg::hart_num];
    rv_pkg::word_t     exwb_data    [rv_pkg::hart_num];

    // a data access without ready freezes every hart.
    assign adv = !mem.mem_stall;

    // ########################################
    // current hart view
    // ########################################
    assign ifid_inst    = ifid_inst_q[cur_hart];
    assign ifid_pc      = ifid_pc_q[cur_hart];
    assign idex_pc      = idex_pc_q[cur_hart];
    assign idex_rs1_val = idex_rs1_q[cur_hart];
    assign idex_rs2_val = idex_rs2_q[cur_hart];

    always_comb begin
        idex_uop       = idex_uop_q[cur_hart];
        idex_uop.valid = idex_valid[cur_hart];
    end

    // load data is forwarded in the cycle the access completes.
    assign exmem_fwd_valid = exmem_wb[cur_hart];
    assign exmem_fwd_rd    = exmem_rd[cur_hart];
    assign exmem_fwd       = exmem_ld[cur_hart] ? mem.load_data : exmem_result[cur_hart];
    assign exwb_fwd_valid  = exwb_valid[cur_hart];
    assign exwb_fwd_rd     = exwb_rd[cur_hart];
    assign exwb_fwd        = exwb_data[cur_hart];

    assign rf_we    = exwb_valid[cur_hart] && adv;
    assign rf_waddr = exwb_rd[cur_hart];
    assign rf_wdata = exwb_data[cur_hart];

    // the memory stage wins the bus over fetch.
    assign mem.data_req   = exmem_ld[cur_hart] || exmem_st[cur_hart];
    assign mem.data_we    = exmem_st[cur_hart];
    assign mem.data_addr  = exmem_result[cur_hart];
    assign mem.data_wdata = exmem_sdata[cur_hart];
    assign mem.fetch_req  = run_q && !mem.data_req;
    assign mem.fetch_addr = pc_q[cur_hart];

    // ########################################
    // stage control
    // ########################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            cur_hart <= '0;
            for (int h = 0; h < rv_pkg::hart_num; h++) begin
                pc_q[h]       <= rv_pkg::hart_reset_pc[h];
                ifid_valid[h] <= 1'b0;
                idex_valid[h] <= 1'b0;
                exmem_wb[h]   <= 1'b0;
                exmem_ld[h]   <= 1'b0;
                exmem_st[h]   <= 1'b0;
                exwb_valid[h] <= 1'b0;
            end
        end else begin
            run_q <= 1'b1;
            if (adv) begin
                cur_hart             <= ~cur_hart;
                exwb_valid[cur_hart] <= exmem_wb[cur_hart];
                exmem_wb[cur_hart]   <= idex_uop.valid && idex_uop.wb_en;
                exmem_ld[cur_hart]   <= idex_uop.valid && idex_uop.is_load;
                exmem_st[cur_hart]   <= idex_uop.valid && idex_uop.is_store;
                // taken branch flushes the younger decode and fetch slots.
                idex_valid[cur_hart] <= ifid_valid[cur_hart] && dec_uop.valid && !br_taken;
                ifid_valid[cur_hart] <= mem.inst_valid && !br_taken;
                if (br_taken) begin
                    pc_q[cur_hart] <= br_target;
                end else if (mem.inst_valid) begin
                    pc_q[cur_hart] <= pc_q[cur_hart] + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            exwb_rd[cur_hart]      <= exmem_rd[cur_hart];
            exwb_data[cur_hart]    <= exmem_fwd;
            exmem_rd[cur_hart]     <= idex_uop.rd;
            exmem_result[cur_hart] <= ex_result;
            exmem_sdata[cur_hart]  <= ex_store_data;
            idex_uop_q[cur_hart]   <= dec_uop;
            idex_pc_q[cur_hart]    <= ifid_pc;
            idex_rs1_q[cur_hart]   <= rf_rdata1;
            idex_rs2_q[cur_hart]   <= rf_rdata2;
            if (mem.inst_valid) begin
                ifid_inst_q[cur_hart] <= mem.inst;
                ifid_pc_q[cur_hart]   <= pc_q[cur_hart];
            end
        end
    end

endmodule

// ==== hw/barrel_core.sv ====
`timescale 1ns/1ps

module barrel_core (
    input  logic          clk,
    input  logic          rst_n,
    output logic          mem_req,
    output logic          mem_we,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    input  rv_pkg::word_t mem_rdata,
    input  logic          mem_ready
);
    rv_pkg::hart_t     cur_hart;
    rv_pkg::word_t     ifid_inst;
    rv_pkg::uop_t      dec_uop;
    rv_pkg::uop_t      idex_uop;
    rv_pkg::word_t     idex_pc;
    rv_pkg::word_t     idex_rs1_val;
    rv_pkg::word_t     idex_rs2_val;
    logic              exmem_fwd_valid;
    rv_pkg::reg_addr_t exmem_fwd_rd;
    rv_pkg::word_t     exmem_fwd;
    logic              exwb_fwd_valid;
    rv_pkg::reg_addr_t exwb_fwd_rd;
    rv_pkg::word_t     exwb_fwd;
    rv_pkg::word_t     ex_result;
    rv_pkg::word_t     ex_store_data;
    logic              br_taken;
    rv_pkg::word_t     br_target;
    rv_pkg::word_t     rf_rdata1;
    rv_pkg::word_t     rf_rdata2;
    logic              rf_we;
    rv_pkg::reg_addr_t rf_waddr;
    rv_pkg::word_t     rf_wdata;

    mem_access_if mem_if ();

    hart_pipe u_pipe (
        .clk(clk), .rst_n(rst_n),
        .dec_uop(dec_uop), .ex_result(ex_result), .ex_store_data(ex_store_data),
        .br_taken(br_taken), .br_target(br_target),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .mem(mem_if),
        .cur_hart(cur_hart), .ifid_inst(ifid_inst), .ifid_pc(),
        .idex_uop(idex_uop), .idex_pc(idex_pc),
        .idex_rs1_val(idex_rs1_val), .idex_rs2_val(idex_rs2_val),
        .exmem_fwd_valid(exmem_fwd_valid), .exmem_fwd_rd(exmem_fwd_rd), .exmem_fwd(exmem_fwd),
        .exwb_fwd_valid(exwb_fwd_valid), .exwb_fwd_rd(exwb_fwd_rd), .exwb_fwd(exwb_fwd),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    inst_decode u_dec (.inst(ifid_inst), .uop(dec_uop));

    exec_unit u_ex (
        .uop(idex_uop), .pc(idex_pc), .rs1_val(idex_rs1_val), .rs2_val(idex_rs2_val),
        .exmem_valid(exmem_fwd_valid), .exmem_rd(exmem_fwd_rd), .exmem_data(exmem_fwd),
        .exwb_valid(exwb_fwd_valid), .exwb_rd(exwb_fwd_rd), .exwb_data(exwb_fwd),
        .result(ex_result), .store_data(ex_store_data),
        .br_taken(br_taken), .br_target(br_target)
    );

    regfile_bank u_rf (
        .clk(clk), .rst_n(rst_n), .r_hart(cur_hart),
        .raddr1(dec_uop.rs1), .raddr2(dec_uop.rs2), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .w_en(rf_we), .w_hart(cur_hart), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    mem_port u_mem (
        .mem(mem_if), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

endmodule

// ==== dv/barrel_core_assert.sv ====
`timescale 1ns/1ps

module barrel_core_assert (
    input logic          clk,
    input logic          rst_n,
    input logic          mem_req,
    input logic          mem_we,
    input rv_pkg::word_t mem_addr,
    input rv_pkg::word_t mem_wdata,
    input logic          mem_ready,
    input logic          data_req
);

    a_we_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> mem_req)
        else $error("mem_we high without mem_req");

    // a waiting load or store must present the same access again.
    a_wait_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && data_req && !mem_ready) |=>
            ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
        else $error("bus changed while a data access waited for mem_ready");

    a_idle_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !mem_req)
        else $error("mem_req high while rst_n is low");

endmodule

bind barrel_core barrel_core_assert u_assert (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
    .data_req(mem_if.data_req)
);

// ==== dv/tb_barrel_core.sv ====
`timescale 1ns/1ps

module tb_barrel_core;

    localparam int timeout_cycles = 20000;
    localparam int quiet_cycles   = 200;
    localparam int max_stores     = 16;

    logic          clk;
    logic          rst_n;
    logic          mem_req;
    logic          mem_we;
    rv_pkg::word_t mem_addr;
    rv_pkg::word_t mem_wdata;
    rv_pkg::word_t mem_rdata;
    logic          mem_ready;

    rv_pkg::word_t mem_words [512];
    rv_pkg::word_t exp_addr  [2][max_stores];
    rv_pkg::word_t exp_data  [2][max_stores];
    rv_pkg::word_t code_base [2] = '{32'h0000_0000, 32'h0000_0400};
    int            exp_cnt   [2];
    int            seen      [2];
    logic          first_seen [2];
    logic [31:0]   lcg_state;
    logic          prev_valid;
    logic          prev_stall;
    rv_pkg::hart_t prev_hart;

    barrel_core dut0 (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

    always #2 clk = ~clk;

    // read data answers in the same cycle as the request.
    assign mem_rdata = (mem_addr < 32'h800) ? mem_words[mem_addr[10:2]] : ~mem_addr;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ########################################
    // checks
    // ########################################
    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp_val,
                              input rv_pkg::word_t act_val);
        if (act_val !== exp_val) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_hart(input string name, input rv_pkg::hart_t exp_val,
                              input rv_pkg::hart_t act_val);
        if (act_val !== exp_val) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic record_store(input rv_pkg::hart_t h);
        if (seen[h] >= exp_cnt[h]) begin
            $display("Error at %0t: hart %0d made a store to %h beyond its expected stores",
                     $time, h, mem_addr);
            abort_run();
        end
        check_word("mem_addr", exp_addr[h][seen[h]], mem_addr);
        check_word("mem_wdata", exp_data[h][seen[h]], mem_wdata);
        mem_words[mem_addr[10:2]] <= mem_wdata;
        seen[h]++;
    endtask

    task automatic load_golden();
        int            fd;
        int            n;
        int            hart_val;
        logic [7:0]    tag;
        logic [8*160-1:0] line;
        rv_pkg::word_t a;
        rv_pkg::word_t d;
        rv_pkg::hart_t h;
        for (int i = 0; i < 512; i++) begin
            mem_words[i] = ~(i << 2);
        end
        fd = $fopen("dv/barrel_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Error: the golden file dv/barrel_core_golden.txt could not be opened");
            abort_run();
        end
        tag = '0;
        n = $fscanf(fd, "%s", tag);
        while (n == 1) begin
            if (tag == "#") begin
                n = $fgets(line, fd);
            end else if (tag == "m" && $fscanf(fd, "%h %h", a, d) == 2) begin
                mem_words[a[10:2]] = d;
            end else if (tag == "s" && $fscanf(fd, "%d %h %h", hart_val, a, d) == 3) begin
                h = rv_pkg::hart_t'(hart_val);
                if (exp_cnt[h] >= max_stores) begin
                    $display("Error: the golden file lists too many stores for hart %0d", h);
                    abort_run();
                end
                exp_addr[h][exp_cnt[h]] = a;
                exp_data[h][exp_cnt[h]] = d;
                exp_cnt[h]++;
            end else begin
                $display("Error: the golden file holds a record that cannot be read");
                abort_run();
            end
            tag = '0;
            n = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
    endtask

    // ########################################
    // memory model and bus monitor
    // ########################################
    always @(posedge clk) begin
        rv_pkg::hart_t h;
        lcg_state <= lcg_next(lcg_state);
        mem_ready <= lcg_state[16];
        if (!rst_n || !mem_req) begin
            prev_valid = 1'b0;
        end else begin
            // address bit 10 splits the harts, bit 9 marks a data region.
            h = mem_addr[10];
            if (prev_valid) begin
                check_hart("mem_addr[10]", prev_stall ? prev_hart : ~prev_hart, h);
            end
            if (!first_seen[h]) begin
                check_word("mem_addr", code_base[h], mem_addr);
                first_seen[h] = 1'b1;
            end
            if (mem_we && mem_ready) begin
                record_store(h);
            end
            prev_valid = 1'b1;
            prev_hart  = h;
            prev_stall = mem_addr[9] && !mem_ready;
        end
    end

    initial begin
        int cycles;
        clk        = 1'b0;
        rst_n      = 1'b0;
        mem_ready  = 1'b0;
        lcg_state  = 32'h6667_78d7;
        prev_valid = 1'b0;
        prev_stall = 1'b0;
        prev_hart  = '0;
        for (int h = 0; h < 2; h++) begin
            exp_cnt[h]    = 0;
            seen[h]       = 0;
            first_seen[h] = 1'b0;
        end
        load_golden();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        cycles = 0;
        while (seen[0] < exp_cnt[0] || seen[1] < exp_cnt[1]) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("Error: store wait timed out, hart 0 %0d/%0d, hart 1 %0d/%0d",
                         seen[0], exp_cnt[0], seen[1], exp_cnt[1]);
                abort_run();
            end
        end

        // any further store is caught by the monitor.
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge clk);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/rv_pkg.sv
hw/mem_access_if.sv
hw/inst_decode.sv
hw/exec_unit.sv
hw/regfile_bank.sv
hw/mem_port.sv
hw/hart_pipe.sv
hw/barrel_core.sv
dv/barrel_core_assert.sv
dv/tb_barrel_core.sv

// ==== Makefile ====
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      ?= tb_barrel_core
FILELIST ?= verilog.f
BUILD    ?= obj_dir
LOG      ?= sim.log

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/barrel_core_golden.txt ====
# m byte_address word preloads the memory model
# s hart byte_address data is the next expected store of that hart
m 00000000 20000093
m 00000004 12345137
m 00000008 67810193
m 0000000c 0030a023
m 00000010 0040a203
m 00000014 003202b3
m 00000018 00021463
m 0000001c 0000a623
m 00000020 40428333
m 00000024 00330463
m 00000028 0040a623
m 0000002c 005343b3
m 00000030 0070a423
m 00000034 00000063
m 00000204 00000010
m 00000400 60000093
m 00000404 0000a103
m 00000408 0040a183
m 0000040c 00312233
m 00000410 003132b3
m 00000414 00419333
m 00000418 406153b3
m 0000041c 0070a423
m 00000420 00029463
m 00000424 00615433
m 00000428 00446433
m 0000042c 003174b3
m 00000430 0080a623
m 00000434 0090a823
m 00000438 00000063
m 00000600 80000005
m 00000604 00000007
s 0 00000200 12345678
s 0 00000208 000000f0
s 1 00000608 fffe0000
s 1 0000060c 00020001
s 1 00000610 00000005
